// ==== verilog/group_noc_pkg.sv ====
// ##########################################################
// Group network package: shared field widths, request and
// flit structs, and the router direction encoding
// ##########################################################

package group_noc_pkg;

  localparam int unsigned GroupCoordWidth = 2;
  localparam int unsigned TileAddrWidth   = 8;  // Bank row plus bank bits
  localparam int unsigned DataWidth       = 32;
  localparam int unsigned MaxTiles        = 16;

  localparam int unsigned TileIdWidth    = $clog2(MaxTiles);
  localparam int unsigned GroupAddrWidth = TileAddrWidth + TileIdWidth;
  localparam int unsigned CoreIdWidth    = 4;
  localparam int unsigned BeWidth        = DataWidth / 8;
  localparam int unsigned NumDirections  = 5;

  // Position of a group in the 4x4 mesh
  typedef struct packed {
    logic [GroupCoordWidth-1:0] x;
    logic [GroupCoordWidth-1:0] y;
  } group_xy_id_t;

  typedef logic [TileIdWidth-1:0] tile_id_t;

  // Master request from a tile remote port
  typedef struct packed {
    logic                      wen;
    logic [BeWidth-1:0]        be;
    logic [DataWidth-1:0]      data;
    group_xy_id_t              tgt_group;
    logic [GroupAddrWidth-1:0] tgt_addr;  // Tile index above the local address
    logic [CoreIdWidth-1:0]    core_id;
  } tcdm_req_t;

  typedef struct packed {
    group_xy_id_t              src_id;
    group_xy_id_t              dst_id;
    tile_id_t                  src_tile_id;
    logic [CoreIdWidth-1:0]    core_id;
    logic [GroupAddrWidth-1:0] tgt_addr;
    logic                      last;
  } floo_req_hdr_t;

  typedef struct packed {
    logic                 wen;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] data;
  } floo_req_payload_t;

  typedef struct packed {
    floo_req_hdr_t     hdr;
    floo_req_payload_t payload;
  } floo_req_t;

  // Request as seen by the target tile
  typedef struct packed {
    logic                     wen;
    logic [BeWidth-1:0]       be;
    logic [DataWidth-1:0]     data;
    logic [TileAddrWidth-1:0] tgt_addr;
    tile_id_t                 ini_addr;
    group_xy_id_t             src_group_id;
    logic [CoreIdWidth-1:0]   core_id;
  } tcdm_slave_req_t;

  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

endpackage

// ==== verilog/tcdm_req_packer.sv ====
// ##########################################################
// Request packer: registers a tile request and builds the
// network flit header from the tile and group position
// ##########################################################
`timescale 1ns/1ns

module tcdm_req_packer
  import group_noc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  group_xy_id_t own_xy_i,
  input  tile_id_t     tile_idx_i,
  input  tcdm_req_t    req_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  output floo_req_t    flit_o,
  output logic         flit_valid_o,
  input  logic         flit_ready_i
);

  floo_req_t flit_d;
  floo_req_t flit_q;
  logic      flit_valid_q;
  logic      load;

  // Slot is free when empty or draining this cycle
  assign req_ready_o = !flit_valid_q || flit_ready_i;
  assign load        = req_valid_i && req_ready_o;

  always_comb begin
    flit_d.hdr.src_id      = own_xy_i;
    flit_d.hdr.dst_id      = req_i.tgt_group;
    flit_d.hdr.src_tile_id = tile_idx_i;
    flit_d.hdr.core_id     = req_i.core_id;
    flit_d.hdr.tgt_addr    = req_i.tgt_addr;
    flit_d.hdr.last        = 1'b1;  // No bursts
    flit_d.payload.wen     = req_i.wen;
    flit_d.payload.be      = req_i.be;
    flit_d.payload.data    = req_i.data;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flit_valid_q <= 1'b0;
    end else if (load) begin
      flit_valid_q <= 1'b1;
    end else if (flit_ready_i) begin
      flit_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      flit_q <= flit_d;
    end
  end

  assign flit_o       = flit_q;
  assign flit_valid_o = flit_valid_q;

endmodule

// ==== verilog/flit_fifo.sv ====
// ##########################################################
// Flit FIFO: circular valid/ready buffer in front of the
// route selection of one tile
// ##########################################################
`timescale 1ns/1ns

module flit_fifo
  import group_noc_pkg::*;
#(
  parameter int unsigned FifoDepth = 2
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  floo_req_t in_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  output floo_req_t out_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  floo_req_t           mem_q [FifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  // Pointer step with wrap for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != CntWidth'(FifoDepth));
  assign out_valid_o = (count_q != '0);
  assign out_o       = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or simultaneous push and pop
      endcase
    end
  end

endmodule

// ==== verilog/xy_route_sel.sv ====
// ##########################################################
// XY route selection: picks a mesh direction or local
// delivery and steers the valid/ready handshake
// ##########################################################
`timescale 1ns/1ns

module xy_route_sel
  import group_noc_pkg::*;
(
  input  group_xy_id_t             own_xy_i,
  input  floo_req_t                flit_i,
  input  logic                     flit_valid_i,
  output logic                     flit_ready_o,
  output logic [NumDirections-1:0] out_valid_o,
  input  logic [NumDirections-1:0] out_ready_i
);

  route_dir_e dir;

  // X first, then Y
  always_comb begin
    if (flit_i.hdr.dst_id.x > own_xy_i.x) begin
      dir = East;
    end else if (flit_i.hdr.dst_id.x < own_xy_i.x) begin
      dir = West;
    end else if (flit_i.hdr.dst_id.y > own_xy_i.y) begin
      dir = North;
    end else if (flit_i.hdr.dst_id.y < own_xy_i.y) begin
      dir = South;
    end else begin
      dir = Local;  // Target is this group
    end
  end

  // One-hot valid on the chosen port only
  always_comb begin
    out_valid_o      = '0;
    out_valid_o[dir] = flit_valid_i;
  end

  assign flit_ready_o = out_ready_i[dir];

endmodule

// ==== verilog/tile_req_xbar.sv ====
// ##########################################################
// Local request crossbar: round-robin grant per target tile
// and unpacking of the winning flit into a slave request
// ##########################################################
`timescale 1ns/1ns

module tile_req_xbar
  import group_noc_pkg::*;
#(
  parameter int unsigned NumTiles = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  floo_req_t       [NumTiles-1:0] flit_i,
  input  logic            [NumTiles-1:0] flit_valid_i,
  output logic            [NumTiles-1:0] flit_ready_o,
  output tcdm_slave_req_t [NumTiles-1:0] slv_req_o,
  output logic            [NumTiles-1:0] slv_valid_o,
  input  logic            [NumTiles-1:0] slv_ready_i
);

  localparam int unsigned SelWidth = (NumTiles > 1) ? $clog2(NumTiles) : 1;

  typedef logic [SelWidth-1:0] sel_t;

  sel_t [NumTiles-1:0]               tgt_sel;
  logic [NumTiles-1:0][NumTiles-1:0] gnt;  // [target][source]

  // Tile index sits right above the tile-local address
  for (genvar s = 0; s < NumTiles; s++) begin : gen_sel
    assign tgt_sel[s] = flit_i[s].hdr.tgt_addr[TileAddrWidth +: SelWidth];
  end

  for (genvar t = 0; t < NumTiles; t++) begin : gen_target
    logic [NumTiles-1:0] req;
    sel_t                win_idx;
    sel_t                rr_q;
    sel_t                lock_idx_q;
    logic                lock_q;
    floo_req_t           win_flit;

    for (genvar s = 0; s < NumTiles; s++) begin : gen_req
      assign req[s] = flit_valid_i[s] && (tgt_sel[s] == sel_t'(t));
      assign gnt[t][s] = req[s] && (win_idx == sel_t'(s));
    end

    // Nearest requester at or after the pointer wins
    always_comb begin
      sel_t cand;
      win_idx = rr_q;
      for (int k = NumTiles - 1; k >= 0; k--) begin
        cand = sel_t'((int'(rr_q) + k) % NumTiles);
        if (req[cand]) win_idx = cand;
      end
      if (lock_q) win_idx = lock_idx_q;  // Hold grant while stalled
    end

    assign win_flit       = flit_i[win_idx];
    assign slv_valid_o[t] = |req;

    always_comb begin
      slv_req_o[t].wen          = win_flit.payload.wen;
      slv_req_o[t].be           = win_flit.payload.be;
      slv_req_o[t].data         = win_flit.payload.data;
      slv_req_o[t].tgt_addr     = win_flit.hdr.tgt_addr[TileAddrWidth-1:0];
      slv_req_o[t].ini_addr     = win_flit.hdr.src_tile_id;
      slv_req_o[t].src_group_id = win_flit.hdr.src_id;
      slv_req_o[t].core_id      = win_flit.hdr.core_id;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rr_q       <= '0;
        lock_q     <= 1'b0;
        lock_idx_q <= '0;
      end else begin
        lock_q     <= slv_valid_o[t] && !slv_ready_i[t];
        lock_idx_q <= win_idx;
        if (slv_valid_o[t] && slv_ready_i[t]) begin
          // Winner drops to lowest priority
          rr_q <= (win_idx == sel_t'(NumTiles - 1)) ? '0 : win_idx + 1'b1;
        end
      end
    end
  end

  always_comb begin
    flit_ready_o = '0;
    for (int s = 0; s < NumTiles; s++) begin
      for (int t = 0; t < NumTiles; t++) begin
        if (gnt[t][s] && slv_ready_i[t]) flit_ready_o[s] = 1'b1;
      end
    end
  end

endmodule

// ==== verilog/group_req_router.sv ====
// ##########################################################
// Group request router: per tile packer, FIFO and XY route
// selection, plus the shared local tile crossbar
// ##########################################################
`timescale 1ns/1ns

module group_req_router
  import group_noc_pkg::*;
#(
  parameter int unsigned NumTiles  = 4,
  parameter int unsigned FifoDepth = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  group_xy_id_t                           group_id_i,
  // Tile master requests
  input  tcdm_req_t       [NumTiles-1:0]         mst_req_i,
  input  logic            [NumTiles-1:0]         mst_valid_i,
  output logic            [NumTiles-1:0]         mst_ready_o,
  // Mesh outputs
  output floo_req_t       [West:North][NumTiles-1:0] floo_req_o,
  output logic            [West:North][NumTiles-1:0] floo_valid_o,
  input  logic            [West:North][NumTiles-1:0] floo_ready_i,
  // Local slave requests
  output tcdm_slave_req_t [NumTiles-1:0]         slv_req_o,
  output logic            [NumTiles-1:0]         slv_valid_o,
  input  logic            [NumTiles-1:0]         slv_ready_i
);

  floo_req_t [NumTiles-1:0] pack_flit;
  logic      [NumTiles-1:0] pack_valid;
  logic      [NumTiles-1:0] pack_ready;
  floo_req_t [NumTiles-1:0] fifo_flit;
  logic      [NumTiles-1:0] fifo_valid;
  logic      [NumTiles-1:0] fifo_ready;
  logic      [NumTiles-1:0][NumDirections-1:0] dir_valid;
  logic      [NumTiles-1:0][NumDirections-1:0] dir_ready;
  logic      [NumTiles-1:0] local_valid;
  logic      [NumTiles-1:0] local_ready;

  for (genvar i = 0; i < NumTiles; i++) begin : gen_tile
    tcdm_req_packer i_packer (
      .clk_i        (clk_i            ),
      .rst_n_i      (rst_n_i          ),
      .own_xy_i     (group_id_i       ),
      .tile_idx_i   (tile_id_t'(i)    ),
      .req_i        (mst_req_i[i]     ),
      .req_valid_i  (mst_valid_i[i]   ),
      .req_ready_o  (mst_ready_o[i]   ),
      .flit_o       (pack_flit[i]     ),
      .flit_valid_o (pack_valid[i]    ),
      .flit_ready_i (pack_ready[i]    )
    );

    flit_fifo #(
      .FifoDepth (FifoDepth)
    ) i_fifo (
      .clk_i       (clk_i         ),
      .rst_n_i     (rst_n_i       ),
      .in_i        (pack_flit[i]  ),
      .in_valid_i  (pack_valid[i] ),
      .in_ready_o  (pack_ready[i] ),
      .out_o       (fifo_flit[i]  ),
      .out_valid_o (fifo_valid[i] ),
      .out_ready_i (fifo_ready[i] )
    );

    xy_route_sel i_route_sel (
      .own_xy_i     (group_id_i    ),
      .flit_i       (fifo_flit[i]  ),
      .flit_valid_i (fifo_valid[i] ),
      .flit_ready_o (fifo_ready[i] ),
      .out_valid_o  (dir_valid[i]  ),
      .out_ready_i  (dir_ready[i]  )
    );

    assign local_valid[i]      = dir_valid[i][Local];
    assign dir_ready[i][Local] = local_ready[i];

    // Same flit fans out to every mesh port
    for (genvar d = int'(North); d <= int'(West); d++) begin : gen_dir
      assign floo_req_o[d][i]   = fifo_flit[i];
      assign floo_valid_o[d][i] = dir_valid[i][d];
      assign dir_ready[i][d]    = floo_ready_i[d][i];
    end
  end

  tile_req_xbar #(
    .NumTiles (NumTiles)
  ) i_xbar (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .flit_i       (fifo_flit   ),
    .flit_valid_i (local_valid ),
    .flit_ready_o (local_ready ),
    .slv_req_o    (slv_req_o   ),
    .slv_valid_o  (slv_valid_o ),
    .slv_ready_i  (slv_ready_i )
  );

endmodule

// ==== bench/group_req_router_assertions.sv ====
// ##########################################################
// Handshake and reset properties of the group request router
// ##########################################################
`timescale 1ns/1ns

module group_req_router_assertions
  import group_noc_pkg::*;
#(
  parameter int unsigned NumTiles = 4
) (
  input logic                                       clk_i,
  input logic                                       rst_n_i,
  input floo_req_t       [West:North][NumTiles-1:0] floo_req_o,
  input logic            [West:North][NumTiles-1:0] floo_valid_o,
  input logic            [West:North][NumTiles-1:0] floo_ready_i,
  input tcdm_slave_req_t [NumTiles-1:0]             slv_req_o,
  input logic            [NumTiles-1:0]             slv_valid_o,
  input logic            [NumTiles-1:0]             slv_ready_i
);

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tile
    // Stalled slave request keeps its valid and data
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slv_valid_o[t] && !slv_ready_i[t] |=> slv_valid_o[t] && $stable(slv_req_o[t]))
      else $error("slave port %0d dropped or changed a stalled request", t);

    for (genvar d = int'(North); d <= int'(West); d++) begin : gen_dir
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
        floo_valid_o[d][t] && !floo_ready_i[d][t]
        |=> floo_valid_o[d][t] && $stable(floo_req_o[d][t]))
        else $error("mesh port %0d of tile %0d dropped or changed a stalled flit", d, t);
    end
  end

  assert property (@(posedge clk_i) !rst_n_i |-> slv_valid_o == '0 && floo_valid_o == '0)
    else $error("output valid high during reset");

  assert property (@(posedge clk_i) $rose(rst_n_i) |-> slv_valid_o == '0 && floo_valid_o == '0)
    else $error("output valid high right after reset");

endmodule

bind group_req_router group_req_router_assertions #(
  .NumTiles (NumTiles)
) i_assertions (
  .clk_i        (clk_i       ),
  .rst_n_i      (rst_n_i     ),
  .floo_req_o   (floo_req_o  ),
  .floo_valid_o (floo_valid_o),
  .floo_ready_i (floo_ready_i),
  .slv_req_o    (slv_req_o   ),
  .slv_valid_o  (slv_valid_o ),
  .slv_ready_i  (slv_ready_i )
);

// ==== bench/tb_group_req_router.sv ====
// ##########################################################
// Testbench for the group request router: table stimulus,
// random output back-pressure and per-port scoreboards
// ##########################################################
`timescale 1ns/1ns

module tb_group_req_router
  import group_noc_pkg::*;
;

  localparam int NumTiles  = 4;
  localparam int FifoDepth = 2;
  localparam int NumRows   = 18;
  localparam group_xy_id_t OwnGroup = '{x: 2'd1, y: 2'd1};

  typedef struct packed {
    logic [1:0]   src;
    group_xy_id_t dst;
    logic [11:0]  addr;
    logic [31:0]  data;
    logic [3:0]   be;
    logic         wen;
    logic [3:0]   core;
  } stim_t;

  logic clk = 1'b0;
  logic rst_n_i;
  group_xy_id_t                                  group_id_i;
  tcdm_req_t       [NumTiles-1:0]                mst_req_i;
  logic            [NumTiles-1:0]                mst_valid_i;
  logic            [NumTiles-1:0]                mst_ready_o;
  floo_req_t       [West:North][NumTiles-1:0]    floo_req_o;
  logic            [West:North][NumTiles-1:0]    floo_valid_o;
  logic            [West:North][NumTiles-1:0]    floo_ready_i;
  tcdm_slave_req_t [NumTiles-1:0]                slv_req_o;
  logic            [NumTiles-1:0]                slv_valid_o;
  logic            [NumTiles-1:0]                slv_ready_i;

  tcdm_slave_req_t exp_slv [NumTiles][$];
  floo_req_t       exp_floo [NumDirections][NumTiles][$];
  int              last_gnt [NumTiles];
  int              errors;
  int              tests_run;
  int              tests_failed;
  logic            bp_en;
  logic            fair_chk;

  // src, dst {x, y}, addr, data, be, wen, core
  stim_t stim_tab [NumRows] = '{
    '{2'd0, '{2'd1, 2'd1}, 12'h1a4, 32'hdead_0001, 4'hf, 1'b1, 4'd3},  // Local rows
    '{2'd1, '{2'd1, 2'd1}, 12'h305, 32'hdead_0002, 4'h3, 1'b0, 4'd5},
    '{2'd2, '{2'd1, 2'd1}, 12'h0ff, 32'hdead_0003, 4'hc, 1'b1, 4'd1},
    '{2'd3, '{2'd1, 2'd1}, 12'h210, 32'hdead_0004, 4'h1, 1'b1, 4'd7},
    '{2'd0, '{2'd1, 2'd1}, 12'h122, 32'hdead_0005, 4'h8, 1'b0, 4'd2},
    '{2'd1, '{2'd3, 2'd1}, 12'h011, 32'hbeef_0001, 4'hf, 1'b1, 4'd0},  // Mesh rows
    '{2'd2, '{2'd0, 2'd2}, 12'h822, 32'hbeef_0002, 4'h6, 1'b0, 4'd9},
    '{2'd3, '{2'd1, 2'd3}, 12'hf33, 32'hbeef_0003, 4'hf, 1'b1, 4'd4},
    '{2'd0, '{2'd1, 2'd0}, 12'h544, 32'hbeef_0004, 4'h2, 1'b1, 4'd8},
    '{2'd1, '{2'd2, 2'd0}, 12'h655, 32'hbeef_0005, 4'h9, 1'b0, 4'd6},
    '{2'd0, '{2'd1, 2'd1}, 12'h240, 32'hc0de_0000, 4'hf, 1'b1, 4'd0},  // All into tile 2
    '{2'd1, '{2'd1, 2'd1}, 12'h241, 32'hc0de_0001, 4'hf, 1'b1, 4'd1},
    '{2'd2, '{2'd1, 2'd1}, 12'h242, 32'hc0de_0002, 4'hf, 1'b0, 4'd2},
    '{2'd3, '{2'd1, 2'd1}, 12'h243, 32'hc0de_0003, 4'hf, 1'b1, 4'd3},
    '{2'd0, '{2'd1, 2'd1}, 12'h2a0, 32'hc0de_0010, 4'h3, 1'b0, 4'd4},
    '{2'd1, '{2'd1, 2'd1}, 12'h2a1, 32'hc0de_0011, 4'h3, 1'b1, 4'd5},
    '{2'd2, '{2'd1, 2'd1}, 12'h2a2, 32'hc0de_0012, 4'h3, 1'b1, 4'd6},
    '{2'd3, '{2'd1, 2'd1}, 12'h2a3, 32'hc0de_0013, 4'h3, 1'b0, 4'd7}
  };

  group_req_router #(
    .NumTiles  (NumTiles ),
    .FifoDepth (FifoDepth)
  ) dut_i (
    .clk_i        (clk         ),
    .rst_n_i      (rst_n_i     ),
    .group_id_i   (group_id_i  ),
    .mst_req_i    (mst_req_i   ),
    .mst_valid_i  (mst_valid_i ),
    .mst_ready_o  (mst_ready_o ),
    .floo_req_o   (floo_req_o  ),
    .floo_valid_o (floo_valid_o),
    .floo_ready_i (floo_ready_i),
    .slv_req_o    (slv_req_o   ),
    .slv_valid_o  (slv_valid_o ),
    .slv_ready_i  (slv_ready_i )
  );

  always #2 clk = ~clk;

  // X before Y, east and north are the larger coordinates
  function automatic route_dir_e expected_dir(group_xy_id_t dst);
    if (dst.x != OwnGroup.x) return (dst.x > OwnGroup.x) ? East : West;
    if (dst.y != OwnGroup.y) return (dst.y > OwnGroup.y) ? North : South;
    return Local;
  endfunction

  function automatic tcdm_req_t make_req(stim_t row);
    tcdm_req_t req;
    req.wen       = row.wen;
    req.be        = row.be;
    req.data      = row.data;
    req.tgt_group = row.dst;
    req.tgt_addr  = row.addr;
    req.core_id   = row.core;
    return req;
  endfunction

  task automatic expect_row(input stim_t row);
    route_dir_e      dir;
    tcdm_slave_req_t s;
    floo_req_t       f;
    dir = expected_dir(row.dst);
    if (dir == Local) begin
      s.wen          = row.wen;
      s.be           = row.be;
      s.data         = row.data;
      s.tgt_addr     = row.addr[7:0];  // Tile bits stripped
      s.ini_addr     = tile_id_t'(row.src);
      s.src_group_id = OwnGroup;
      s.core_id      = row.core;
      exp_slv[row.addr[9:8]].push_back(s);
    end else begin
      f.hdr.src_id      = OwnGroup;
      f.hdr.dst_id      = row.dst;
      f.hdr.src_tile_id = tile_id_t'(row.src);
      f.hdr.core_id     = row.core;
      f.hdr.tgt_addr    = row.addr;
      f.hdr.last        = 1'b1;
      f.payload.wen     = row.wen;
      f.payload.be      = row.be;
      f.payload.data    = row.data;
      exp_floo[int'(dir)][row.src].push_back(f);
    end
  endtask

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_floo(input int d, input int t);
    floo_req_t exp;
    if (exp_floo[d][t].size() == 0) begin
      $display("unexpected flit on mesh port %0d of tile %0d at %0t ns", d, t, $time);
      errors++;
    end else begin
      exp = exp_floo[d][t].pop_front();
      check_val($sformatf("floo_req_o[%0d][%0d]", d, t), 128'(exp), 128'(floo_req_o[d][t]));
    end
  endtask

  // The crossbar may interleave sources, so match the oldest entry of the same source
  task automatic check_slv(input int t);
    tcdm_slave_req_t act;
    int              idx;
    bit              others;
    act    = slv_req_o[t];
    idx    = -1;
    others = 1'b0;
    for (int k = exp_slv[t].size() - 1; k >= 0; k--) begin
      if (exp_slv[t][k].ini_addr == act.ini_addr) idx = k;
    end
    if (idx < 0) begin
      $display("unexpected request on slave port %0d from tile %0d at %0t ns",
               t, act.ini_addr, $time);
      errors++;
    end else begin
      check_val($sformatf("slv_req_o[%0d]", t), 128'(exp_slv[t][idx]), 128'(act));
      exp_slv[t].delete(idx);
      for (int k = 0; k < exp_slv[t].size(); k++) begin
        if (exp_slv[t][k].ini_addr != act.ini_addr) others = 1'b1;
      end
      if (fair_chk && last_gnt[t] == int'(act.ini_addr) && others) begin
        $display("tile %0d was granted twice in a row on slave port %0d while another waits",
                 act.ini_addr, t);
        errors++;
      end
      last_gnt[t] = int'(act.ini_addr);
    end
  endtask

  // Transfers are counted at the falling edge, where valid and ready are settled
  always @(negedge clk) begin
    if (rst_n_i) begin
      for (int t = 0; t < NumTiles; t++) begin
        if (slv_valid_o[t] && slv_ready_i[t]) check_slv(t);
        for (int d = int'(North); d <= int'(West); d++) begin
          if (floo_valid_o[d][t] && floo_ready_i[d][t]) check_floo(d, t);
        end
      end
    end
  end

  initial begin : ready_gen
    logic [31:0] rnd;
    rnd          = $urandom(68234);
    slv_ready_i  = '1;
    floo_ready_i = '1;
    forever begin
      @(posedge clk);
      rnd = $urandom;
      if (bp_en) begin
        slv_ready_i  <= rnd[3:0];
        floo_ready_i <= rnd[19:4];
      end else begin
        slv_ready_i  <= '1;
        floo_ready_i <= '1;
      end
    end
  end

  task automatic drive_tile(input int t, input int lo, input int hi);
    int wait_cyc;
    for (int r = lo; r < hi; r++) begin
      if (int'(stim_tab[r].src) == t) begin
        expect_row(stim_tab[r]);
        @(posedge clk);
        mst_req_i[t]   <= make_req(stim_tab[r]);
        mst_valid_i[t] <= 1'b1;
        wait_cyc = 0;
        @(negedge clk);
        while (!mst_ready_o[t] && wait_cyc < 200) begin
          @(negedge clk);
          wait_cyc++;
        end
        if (!mst_ready_o[t]) begin
          $display("request of row %0d was never accepted by tile %0d", r, t);
          errors++;
        end
        @(posedge clk);
        mst_valid_i[t] <= 1'b0;
      end
    end
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < NumTiles; t++) begin
      n += exp_slv[t].size();
      for (int d = 0; d < NumDirections; d++) n += exp_floo[d][t].size();
    end
    return n;
  endfunction

  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while (pending_count() != 0 && cyc < 500) begin
      @(negedge clk);
      cyc++;
    end
    if (pending_count() != 0) begin
      $display("%0d expected requests never left the router", pending_count());
      errors++;
      for (int t = 0; t < NumTiles; t++) begin
        exp_slv[t].delete();
        for (int d = 0; d < NumDirections; d++) exp_floo[d][t].delete();
      end
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %-12s ok", name);
    end else begin
      $display("test %-12s failed with %0d errors", name, errors - err0);
      tests_failed++;
    end
  endtask

  task automatic run_test(input string name, input int lo, input int hi, input logic bp,
                          input logic fair);
    int err0;
    err0     = errors;
    bp_en    = bp;
    fair_chk = fair;
    for (int t = 0; t < NumTiles; t++) last_gnt[t] = -1;
    fork
      drive_tile(0, lo, hi);
      drive_tile(1, lo, hi);
      drive_tile(2, lo, hi);
      drive_tile(3, lo, hi);
    join
    wait_drain();
    report_test(name, err0);
  endtask

  task automatic check_reset_outputs();
    check_val("slv_valid_o", 128'(0), 128'(slv_valid_o));
    check_val("floo_valid_o", 128'(0), 128'(floo_valid_o));
    check_val("mst_ready_o", 128'(4'hf), 128'(mst_ready_o));
  endtask

  initial begin
    int err0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    bp_en        = 1'b0;
    fair_chk     = 1'b0;
    rst_n_i      = 1'b0;
    group_id_i   = OwnGroup;
    mst_req_i    = '0;
    mst_valid_i  = '0;
    err0         = errors;
    repeat (3) begin
      @(negedge clk);
      check_reset_outputs();
    end
    @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_reset_outputs();  // First cycle out of reset
    report_test("reset", err0);
    run_test("local", 0, 5, 1'b0, 1'b0);
    run_test("xy_route", 5, 10, 1'b0, 1'b0);
    run_test("contention", 10, 18, 1'b0, 1'b1);
    run_test("backpressure", 0, NumRows, 1'b1, 1'b0);
    $display("%0d tests run, %0d failed, %0d errors in total", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
verilog/group_noc_pkg.sv
verilog/tcdm_req_packer.sv
verilog/flit_fifo.sv
verilog/xy_route_sel.sv
verilog/tile_req_xbar.sv
verilog/group_req_router.sv
bench/group_req_router_assertions.sv
bench/tb_group_req_router.sv

// ==== Bender.yml ====
package:
  name: group_req_router

sources:
  - files:
      - verilog/group_noc_pkg.sv
      - verilog/tcdm_req_packer.sv
      - verilog/flit_fifo.sv
      - verilog/xy_route_sel.sv
      - verilog/tile_req_xbar.sv
      - verilog/group_req_router.sv
  - target: test
    files:
      - bench/group_req_router_assertions.sv
      - bench/tb_group_req_router.sv
